/* alu.sv */
`timescale 1ns/1ps

module alu
    import rv_isa_pkg::*, core_ctrl_pkg::*;
(
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output word_t result
);

    word_t op_a;
    word_t op_b;

    // Operand A is pc for AUIPC, zero for LUI
    always_comb begin
        case (ctrl.opa_sel)
            OPA_PC:   op_a = pc;
            OPA_ZERO: op_a = '0;
            default:  op_a = rs1_data;
        endcase
    end

    assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT: begin
                result = word_t'($signed(op_a) < $signed(op_b));
            end
            ALU_SLTU: begin
                result = word_t'(op_a < op_b); // Unsigned compare
            end
            default:  result = op_a + op_b;
        endcase
    end

endmodule

/* core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and address width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// Data memory depth in words
`define DMEM_WORDS 256

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

/* core_ctrl_pkg.sv */
package core_ctrl_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6
    } alu_op_e;

    // First ALU operand source
    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_PC   = 2'd1,
        OPA_ZERO = 2'd2
    } opa_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        opa_sel_e opa_sel;
        logic     use_imm;   // Operand B is the immediate
        logic     reg_write;
        logic     mem_read;  // Also selects load data for writeback
        logic     mem_write;
        logic     branch;
        logic     branch_ne; // Taken on inequality
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } ctrl_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    rd_data;
        logic     reg_write;
        logic     mem_write;
        word_t    mem_addr;
        word_t    mem_data;
    } retire_t;

endpackage

/* fetch_pc.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module fetch_pc
    import rv_isa_pkg::*, core_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  instr_valid,
    input  ctrl_t ctrl,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output word_t pc
);

    logic  operands_equal;
    logic  branch_taken;
    word_t pc_plus4;
    word_t pc_target;
    word_t pc_next;

    // BEQ wants equal operands, BNE wants them to differ
    assign operands_equal = (rs1_data == rs2_data);
    assign branch_taken   = ctrl.branch && (operands_equal != ctrl.branch_ne);

    assign pc_plus4  = pc + word_t'(4);
    assign pc_target = pc + ctrl.imm; // B-type offset, already shifted
    assign pc_next   = branch_taken ? pc_target : pc_plus4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (instr_valid) begin
            pc <= pc_next; // Advance only on an accepted instruction
        end
    end

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module instr_decoder
    import rv_isa_pkg::*, core_ctrl_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  ctrl
);

    opcode_e opcode;
    funct3_t funct3;
    logic    funct7_b30;
    logic    arith_ok;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;

    function automatic alu_op_e alu_from_funct3(input funct3_t f3, input logic sub);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = sub ? ALU_SUB : ALU_ADD;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_b30 = instr[30];

    // Shift encodings are not implemented
    assign arith_ok = (funct3 != 3'b001) && (funct3 != 3'b101);

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        ctrl         = '0; // Unknown opcodes leave all side effects off
        ctrl.alu_op  = ALU_ADD;
        ctrl.opa_sel = OPA_RS1;
        ctrl.rd      = instr[11:7];
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.imm     = imm_i;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = alu_from_funct3(funct3, funct7_b30);
                ctrl.reg_write = arith_ok;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = alu_from_funct3(funct3, 1'b0); // funct7 ignored
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = arith_ok;
            end
            OPC_LOAD: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = (funct3 == F3_LW);
                ctrl.reg_write = (funct3 == F3_LW);
            end
            OPC_STORE: begin
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_s;
                ctrl.mem_write = (funct3 == F3_SW);
            end
            OPC_BRANCH: begin
                ctrl.imm       = imm_b;
                ctrl.branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                ctrl.branch_ne = (funct3 == F3_BNE);
            end
            OPC_LUI: begin
                ctrl.opa_sel   = OPA_ZERO; // 0 + imm
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.opa_sel   = OPA_PC;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* mem_writeback.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module mem_writeback
    import rv_isa_pkg::*, core_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  ctrl_t   ctrl,
    input  word_t   pc,
    input  word_t   alu_result,
    input  word_t   rs2_data,
    output word_t   rd_data,
    output logic    retire_valid,
    output retire_t retire
);

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    word_t             dmem [`DMEM_WORDS];
    logic [ADDR_W-1:0] word_addr;
    logic              rd_live;
    retire_t           retire_next;

    assign word_addr = alu_result[ADDR_W+1:2]; // Word index, wraps at the depth

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (instr_valid && ctrl.mem_write) begin
            dmem[word_addr] <= rs2_data;
        end
    end

    assign rd_data = ctrl.mem_read ? dmem[word_addr] : alu_result;

    // Record shows zero data unless a real register is written
    assign rd_live = ctrl.reg_write && (ctrl.rd != '0);

    always_comb begin
        retire_next.pc        = pc;
        retire_next.rd        = ctrl.rd;
        retire_next.rd_data   = rd_live ? rd_data : '0;
        retire_next.reg_write = ctrl.reg_write;
        retire_next.mem_write = ctrl.mem_write;
        retire_next.mem_addr  = alu_result;
        retire_next.mem_data  = rs2_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire <= retire_next;
        end
    end

endmodule

/* register_file.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module register_file
    import rv_isa_pkg::*, core_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  instr_valid,
    input  ctrl_t ctrl,
    input  word_t rd_data,
    output word_t rs1_data,
    output word_t rs2_data
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (instr_valid && ctrl.reg_write && (ctrl.rd != '0)) begin
            regs[ctrl.rd] <= rd_data; // x0 keeps its reset value
        end
    end

    // Asynchronous reads
    assign rs1_data = regs[ctrl.rs1];
    assign rs2_data = regs[ctrl.rs2];

endmodule

/* riscv_core.sv */
`timescale 1ns/1ps

module riscv_core
    import rv_isa_pkg::*, core_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  instr_t  instr,
    output word_t   pc,
    output logic    retire_valid,
    output retire_t retire
);

    ctrl_t ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    word_t rd_data; // Writeback value back into the register file

    fetch_pc i_fetch_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc)
    );

    instr_decoder i_instr_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    register_file i_register_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .rd_data     (rd_data),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    alu i_alu (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    mem_writeback i_mem_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .ctrl         (ctrl),
        .pc           (pc),
        .alu_result   (alu_result),
        .rs2_data     (rs2_data),
        .rd_data      (rd_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* riscv_core_sva.sv */
`timescale 1ns/1ps

module riscv_core_sva
    import rv_isa_pkg::*, core_ctrl_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    instr_valid,
    input logic    retire_valid,
    input retire_t retire,
    input ctrl_t   ctrl,
    input word_t   rs1_data,
    input word_t   rs2_data
);

    // Every accepted strobe retires on the next edge
    strobe_retires: assert property (
        @(posedge clk) disable iff (!rst_n) instr_valid |=> retire_valid
    ) else $error("retire_valid missing one cycle after a strobe");

    no_spurious_retire: assert property (
        @(posedge clk) disable iff (!rst_n) !instr_valid |=> !retire_valid
    ) else $error("retire_valid high without a strobe in the previous cycle");

    // First edge out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !retire_valid
    ) else $error("retire_valid high right after reset");

    x0_retire_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
            (retire_valid && retire.rd == '0) |-> (retire.rd_data == '0)
    ) else $error("Retire to x0 reports nonzero data");

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
            (ctrl.rs1 != '0 || rs1_data == '0) && (ctrl.rs2 != '0 || rs2_data == '0)
    ) else $error("Read of x0 returned nonzero data");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash

TOP=tb_riscv_core
BUILD_DIR=obj_dir
LOG_FILE=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$TOP" -f sources.f \
    --Mdir "$BUILD_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG_FILE"; then
    exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1

/* rv_isa_pkg.sv */
`include "core_config.svh"

package rv_isa_pkg;

    localparam int INSTR_W   = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [`XLEN-1:0]     word_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // Arithmetic and logic funct3, shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_LW  = 3'b010; // Word load and store only
    localparam funct3_t F3_SW  = 3'b010;
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

endpackage

/* sources.f */
+incdir+.
rv_isa_pkg.sv
core_ctrl_pkg.sv
fetch_pc.sv
instr_decoder.sv
register_file.sv
alu.sv
mem_writeback.sv
riscv_core.sv
riscv_core_sva.sv
tb_riscv_core.sv

/* tb_riscv_core.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module tb_riscv_core
    import rv_isa_pkg::*, core_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 300;
    localparam int RETIRE_WAIT  = 4;
    localparam int WATCHDOG_NS  = (NUM_INSTR * 2 + RESET_CYCLES + 2 * RETIRE_WAIT) * CLK_PERIOD;
    localparam int DMEM_AW      = $clog2(`DMEM_WORDS);
    localparam logic [31:0] LCG_MUL = 32'd1103515245;
    localparam logic [31:0] LCG_INC = 32'd12345;
    localparam funct3_t ARITH_F3 [6] = '{F3_ADD_SUB, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_t      instr;
    word_t       pc;
    logic        retire_valid;
    retire_t     retire;

    word_t       shadow_regs [`REG_COUNT];
    word_t       shadow_mem [`DMEM_WORDS];
    word_t       shadow_pc;
    logic [31:0] lcg_state;
    int          checks;
    int          value_errors;
    int          handshake_errors;

    riscv_core i_riscv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    bind riscv_core riscv_core_sva i_riscv_core_sva (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .retire_valid (retire_valid),
        .retire       (retire),
        .ctrl         (ctrl),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the instruction stream did not finish",
                 WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic int pick_below(input int n);
        lcg_state = lcg_state * LCG_MUL + LCG_INC;
        return int'(lcg_state[30:16]) % n; // Upper bits since the low ones cycle fast
    endfunction

    function automatic word_t next_word();
        logic [31:0] hi;
        lcg_state = lcg_state * LCG_MUL + LCG_INC;
        hi = lcg_state;
        lcg_state = lcg_state * LCG_MUL + LCG_INC;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    // Reference results straight from the ISA definitions
    function automatic word_t arith_ref(input funct3_t f3, input logic sub, input word_t a,
                                        input word_t b);
        word_t res;
        case (f3)
            F3_ADD_SUB: res = sub ? a - b : a + b;
            F3_SLT:     res = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            F3_SLTU:    res = (a < b) ? word_t'(1) : '0;
            F3_XOR:     res = a ^ b;
            F3_OR:      res = a | b;
            default:    res = a & b;
        endcase
        return res;
    endfunction

    function automatic instr_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                      input funct3_t f3, input reg_idx_t rd, input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t u_type(input word_t imm, input reg_idx_t rd, input opcode_e op);
        return {imm[31:12], rd, op};
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One random instruction, predicted by the shadow state, then issued and checked
    task automatic run_one(input int n);
        int                 kind;
        int                 waited;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        reg_idx_t           rs2;
        funct3_t            f3;
        logic               sub;
        logic               writes;
        logic               store;
        logic [DMEM_AW-1:0] widx;
        word_t              raw;
        word_t              imm;
        word_t              a;
        word_t              b;
        word_t              exp_rd;
        word_t              exp_pc;
        word_t              addr;
        instr_t             word;
        string              name;

        kind   = pick_below(7);
        rd     = reg_idx_t'(pick_below(8)); // Few registers give many dependencies
        rs1    = reg_idx_t'(pick_below(8));
        rs2    = reg_idx_t'(pick_below(8));
        f3     = ARITH_F3[pick_below(6)];
        sub    = (f3 == F3_ADD_SUB) && (pick_below(2) == 1);
        raw    = next_word();
        imm    = {{(`XLEN-12){raw[31]}}, raw[31:20]};
        widx   = DMEM_AW'(pick_below(16));
        addr   = word_t'(widx) << 2;
        store  = 1'b0;
        writes = 1'b1;
        exp_rd = '0;
        exp_pc = shadow_pc + 4;
        if (kind == 2 || kind == 3) begin
            rs1 = '0; // Word accesses use x0 as base
        end
        a = shadow_regs[rs1];
        b = shadow_regs[rs2];
        case (kind)
            0: begin
                word   = r_type(sub ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
                exp_rd = arith_ref(f3, sub, a, b);
                name   = "op";
            end
            1: begin
                word   = i_type(imm[11:0], rs1, f3, rd, OPC_OP_IMM);
                exp_rd = arith_ref(f3, 1'b0, a, imm);
                name   = "op_imm";
            end
            2: begin
                word   = s_type(addr[11:0], rs2, rs1, F3_SW);
                store  = 1'b1;
                writes = 1'b0;
                name   = "sw";
            end
            3: begin
                word   = i_type(addr[11:0], rs1, F3_LW, rd, OPC_LOAD);
                exp_rd = shadow_mem[widx];
                name   = "lw";
            end
            4: begin
                f3     = (pick_below(2) == 1) ? F3_BNE : F3_BEQ;
                imm    = word_t'((pick_below(16) - 8) * 4);
                word   = b_type(imm[12:0], rs2, rs1, f3);
                writes = 1'b0;
                name   = (f3 == F3_BNE) ? "bne" : "beq";
                if ((a == b) != (f3 == F3_BNE)) begin
                    exp_pc = shadow_pc + imm; // Taken
                end
            end
            5: begin
                imm    = {raw[31:12], 12'b0};
                word   = u_type(imm, rd, OPC_LUI);
                exp_rd = imm;
                name   = "lui";
            end
            default: begin
                imm    = {raw[31:12], 12'b0};
                word   = u_type(imm, rd, OPC_AUIPC);
                exp_rd = shadow_pc + imm;
                name   = "auipc";
            end
        endcase
        if (!writes || rd == '0) begin
            exp_rd = '0;
        end
        name = $sformatf("#%0d %s", n, name);

        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        @(posedge clk);
        instr_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!retire_valid && waited < RETIRE_WAIT) begin
            @(negedge clk);
            waited++;
        end

        if (!retire_valid) begin
            handshake_errors++;
            $display("Instruction %s never produced a retire pulse", name);
        end else begin
            check_word({name, " retire.pc"}, shadow_pc, retire.pc);
            check_word({name, " rd_data"}, exp_rd, retire.rd_data);
            check_word({name, " reg_write"}, word_t'(writes), word_t'(retire.reg_write));
            check_word({name, " mem_write"}, word_t'(store), word_t'(retire.mem_write));
            if (writes) begin
                check_word({name, " rd"}, word_t'(rd), word_t'(retire.rd));
            end
            if (store) begin
                check_word({name, " mem_addr"}, addr, retire.mem_addr);
                check_word({name, " mem_data"}, b, retire.mem_data);
            end
            check_word({name, " next pc"}, exp_pc, pc);
        end

        if (writes && rd != '0) begin
            shadow_regs[rd] = exp_rd;
        end
        if (store) begin
            shadow_mem[widx] = b;
        end
        shadow_pc = exp_pc;
    endtask

    initial begin
        rst_n            = 1'b0;
        instr_valid      = 1'b0;
        instr            = '0;
        lcg_state        = 32'd81;
        checks           = 0;
        value_errors     = 0;
        handshake_errors = 0;
        shadow_pc        = `RESET_PC;
        shadow_regs      = '{default: '0};
        shadow_mem       = '{default: '0};

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int n = 0; n < NUM_INSTR; n++) begin
            run_one(n);
        end
        repeat (2) @(posedge clk);

        $display("Checks run: %0d, value errors: %0d, handshake errors: %0d",
                 checks, value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
